// ==== verilog/board_pkg.sv ====
// Shared pad structs for the board shell
// SPI host and I2C drive bundles, I2C sense levels and SD slot pins
// Default values for the top-level parameters

`default_nettype none

package board_pkg;

  //////////////////////////////////////////////////////////////////////
  // Pad bundles
  //////////////////////////////////////////////////////////////////////

  // SPI host drive from the SoC, 14 bits
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd;
    logic [3:0] sd_en;
  } spih_out_t;

  // I2C drive from the SoC
  typedef struct packed {
    logic scl;
    logic scl_en;
    logic sda;
    logic sda_en;
  } i2c_out_t;

  // Synchronized I2C pin levels back to the SoC
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_in_t;

  // SD slot in SPI mode, dat3 acts as chip select
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic       dat3;
    logic [1:0] dat12;
  } sd_pins_t;

  //////////////////////////////////////////////////////////////////////
  // Defaults
  //////////////////////////////////////////////////////////////////////

  localparam int FanSettingWidth = 4;

  // 50 MHz soc_clk down to a 1 MHz RTC level
  localparam int DefaultRtcHalfPeriod = 25;
  localparam int DefaultFanPrescale   = 8;
  localparam int DefaultSyncStages    = 2;

endpackage

`default_nettype wire

// ==== verilog/rst_sync.sv ====
// Reset synchronizer for the soc_clk domain
// Immediate assertion, release aligned to soc_clk

`timescale 1ns/10ps
`default_nettype none

module rst_sync
  import board_pkg::*;
#(
  parameter int SyncStages = DefaultSyncStages
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic soc_rst_no
);

  logic [SyncStages-1:0] sync_q;

  // Ones shift in once rst_n is high
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= 1'b1;
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage is the released reset
  assign soc_rst_no = sync_q[SyncStages-1];

endmodule

`default_nettype wire

// ==== verilog/rtc_clk_div.sv ====
// Real-time-clock divider
// Toggles a level every HalfPeriod cycles of soc_clk

`timescale 1ns/10ps
`default_nettype none

module rtc_clk_div
  import board_pkg::*;
#(
  parameter int HalfPeriod = DefaultRtcHalfPeriod
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int CntWidth = (HalfPeriod > 1) ? $clog2(HalfPeriod) : 1;

  logic [CntWidth-1:0] cnt_d, cnt_q;
  logic                rtc_d, rtc_q;

  // Count 0 .. HalfPeriod-1, flip the level on wrap
  always_comb begin
    cnt_d = cnt_q + CntWidth'(1);
    rtc_d = rtc_q;
    if (cnt_q == CntWidth'(HalfPeriod - 1)) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  assign rtc_o = rtc_q;

endmodule

`default_nettype wire

// ==== verilog/fan_pwm_ctrl.sv ====
// Fan PWM controller
// Prescaler tick, sixteen-phase counter and registered duty compare
// Setting is captured once per PWM period

`timescale 1ns/10ps
`default_nettype none

module fan_pwm_ctrl
  import board_pkg::*;
#(
  parameter int Prescale = DefaultFanPrescale
) (
  input  logic                       soc_clk,
  input  logic                       rst_n,
  input  logic [FanSettingWidth-1:0] fan_setting_i,
  output logic                       fan_pwm_o
);

  localparam int PreWidth = (Prescale > 1) ? $clog2(Prescale) : 1;

  logic [PreWidth-1:0]        pre_d, pre_q;
  logic [FanSettingWidth-1:0] phase_d, phase_q;
  logic [FanSettingWidth-1:0] setting_d, setting_q;
  logic                       tick;
  logic                       wrap;
  logic                       pwm_d, pwm_q;

  //////////////////////////////////////////////////////////////////////
  // Prescaler and phase
  //////////////////////////////////////////////////////////////////////

  assign tick = (pre_q == PreWidth'(Prescale - 1));
  assign wrap = tick && (phase_q == '1);

  always_comb begin
    pre_d   = tick ? '0 : pre_q + PreWidth'(1);
    // Phase rolls over naturally at the top
    phase_d = tick ? phase_q + FanSettingWidth'(1) : phase_q;
  end

  //////////////////////////////////////////////////////////////////////
  // Duty
  //////////////////////////////////////////////////////////////////////

  // New setting only at the start of a period
  assign setting_d = wrap ? fan_setting_i : setting_q;

  // Compare on next-state values so the output lines up with the phase
  assign pwm_d = (phase_d < setting_d);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q     <= '0;
      phase_q   <= '0;
      setting_q <= '0;
      pwm_q     <= 1'b0;
    end else begin
      pre_q     <= pre_d;
      phase_q   <= phase_d;
      setting_q <= setting_d;
      pwm_q     <= pwm_d;
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

`default_nettype wire

// ==== verilog/board_pad_ctrl.sv ====
// Pad adapter between the SoC and the board pins
// SPI host onto the SD slot in SPI mode, I2C pad drive
// Input synchronizers for SCL, SDA and card detect

`timescale 1ns/10ps
`default_nettype none

module board_pad_ctrl
  import board_pkg::*;
#(
  parameter int SyncStages = DefaultSyncStages
) (
  input  logic      soc_clk,
  input  logic      rst_n,

  // SPI host and SD slot
  input  spih_out_t spih_i,
  input  logic      sd_dat0_i,
  input  logic      sd_cd_i,
  output sd_pins_t  sd_o,
  output logic [3:0] spih_sd_o,

  // I2C
  input  i2c_out_t  i2c_i,
  input  logic      i2c_scl_pin_i,
  input  logic      i2c_sda_pin_i,
  output logic      i2c_scl_oe_o,
  output logic      i2c_sda_oe_o,
  output logic      i2c_scl_drv_o,
  output logic      i2c_sda_drv_o,
  output i2c_in_t   i2c_sync_o,
  output logic      sd_card_present_o
);

  // Bit order {card detect, sda, scl}
  localparam logic [2:0] SyncRstVal = 3'b011;

  logic [2:0]                  pins_raw;
  logic [SyncStages-1:0][2:0]  sync_q;
  logic [2:0]                  pins_sync;

  //////////////////////////////////////////////////////////////////////
  // SD slot mapping
  //////////////////////////////////////////////////////////////////////

  // Lines idle high whenever the host is not driving them
  assign sd_o.sclk  = spih_i.sck_en    ? spih_i.sck    : 1'b1;
  assign sd_o.dat3  = spih_i.csb_en[0] ? spih_i.csb[0] : 1'b1;
  assign sd_o.cmd   = spih_i.sd_en[0]  ? spih_i.sd[0]  : 1'b1;
  // DAT1 and DAT2 unused in SPI mode
  assign sd_o.dat12 = 2'b11;

  // MISO comes back on host data bit 1
  assign spih_sd_o = {2'b00, sd_dat0_i, 1'b0};

  //////////////////////////////////////////////////////////////////////
  // I2C drive
  //////////////////////////////////////////////////////////////////////

  assign i2c_scl_oe_o  = i2c_i.scl_en;
  assign i2c_sda_oe_o  = i2c_i.sda_en;
  assign i2c_scl_drv_o = i2c_i.scl;
  assign i2c_sda_drv_o = i2c_i.sda;

  //////////////////////////////////////////////////////////////////////
  // Input synchronizers
  //////////////////////////////////////////////////////////////////////

  assign pins_raw = {sd_cd_i, i2c_sda_pin_i, i2c_scl_pin_i};

  // I2C lines rest high, no card until seen
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= {SyncStages{SyncRstVal}};
    end else begin
      sync_q[0] <= pins_raw;
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign pins_sync = sync_q[SyncStages-1];

  assign i2c_sync_o.scl    = pins_sync[0];
  assign i2c_sync_o.sda    = pins_sync[1];
  assign sd_card_present_o = pins_sync[2];

endmodule

`default_nettype wire

// ==== verilog/board_shell_top.sv ====
// Board shell top level
// Reset synchronizer, RTC divider, fan PWM and pad adapter

`timescale 1ns/10ps
`default_nettype none

module board_shell_top
  import board_pkg::*;
#(
  parameter int RtcHalfPeriod = DefaultRtcHalfPeriod,
  parameter int FanPrescale   = DefaultFanPrescale,
  parameter int SyncStages    = DefaultSyncStages
) (
  input  logic                       soc_clk,
  input  logic                       rst_n,

  // Fan and RTC
  input  logic [FanSettingWidth-1:0] fan_sw_i,
  output logic                       fan_pwm_o,
  output logic                       rtc_o,

  // SPI host and SD slot
  input  spih_out_t                  spih_i,
  input  logic                       sd_dat0_i,
  input  logic                       sd_cd_i,
  output sd_pins_t                   sd_o,
  output logic [3:0]                 spih_sd_o,

  // I2C
  input  i2c_out_t                   i2c_i,
  input  logic                       i2c_scl_pin_i,
  input  logic                       i2c_sda_pin_i,
  output logic                       i2c_scl_oe_o,
  output logic                       i2c_sda_oe_o,
  output logic                       i2c_scl_drv_o,
  output logic                       i2c_sda_drv_o,
  output i2c_in_t                    i2c_sync_o,
  output logic                       sd_card_present_o
);

  // Internal reset, released in step with soc_clk
  logic soc_rst_n;

  rst_sync #(
    .SyncStages ( SyncStages )
  ) i_rst_sync (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( rst_n      ),
    .soc_rst_no ( soc_rst_n  )
  );

  rtc_clk_div #(
    .HalfPeriod ( RtcHalfPeriod )
  ) i_rtc_clk_div (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( soc_rst_n  ),
    .rtc_o      ( rtc_o      )
  );

  fan_pwm_ctrl #(
    .Prescale      ( FanPrescale )
  ) i_fan_pwm_ctrl (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( soc_rst_n   ),
    .fan_setting_i ( fan_sw_i    ),
    .fan_pwm_o     ( fan_pwm_o   )
  );

  board_pad_ctrl #(
    .SyncStages        ( SyncStages        )
  ) i_board_pad_ctrl (
    .soc_clk           ( soc_clk           ),
    .rst_n             ( soc_rst_n         ),
    .spih_i            ( spih_i            ),
    .sd_dat0_i         ( sd_dat0_i         ),
    .sd_cd_i           ( sd_cd_i           ),
    .sd_o              ( sd_o              ),
    .spih_sd_o         ( spih_sd_o         ),
    .i2c_i             ( i2c_i             ),
    .i2c_scl_pin_i     ( i2c_scl_pin_i     ),
    .i2c_sda_pin_i     ( i2c_sda_pin_i     ),
    .i2c_scl_oe_o      ( i2c_scl_oe_o      ),
    .i2c_sda_oe_o      ( i2c_sda_oe_o      ),
    .i2c_scl_drv_o     ( i2c_scl_drv_o     ),
    .i2c_sda_drv_o     ( i2c_sda_drv_o     ),
    .i2c_sync_o        ( i2c_sync_o        ),
    .sd_card_present_o ( sd_card_present_o )
  );

endmodule

`default_nettype wire

// ==== verif/tb_board_shell.sv ====
// Testbench for the board shell top level
// Clock and reset, a value checker and table-driven tests for
// reset values, RTC period, fan duty, SD mapping, I2C and resync

`timescale 1ns/10ps
`default_nettype none

module tb_board_shell
  import board_pkg::*;
;

  localparam int RtcHalfPeriod = 25;
  localparam int FanPrescale   = 8;
  localparam int SyncStages    = 2;
  localparam int ResetCycles   = 10;
  localparam int FanPeriod     = 16 * FanPrescale;
  localparam int RtcTimeout    = 4 * RtcHalfPeriod;
  localparam int NumFanRows    = 5;
  localparam int NumSdRows     = 8;
  localparam int NumI2cRows    = 6;
  localparam int NumPinRows    = 5;

  logic                       soc_clk;
  logic                       rst_n;
  logic [FanSettingWidth-1:0] fan_sw_i;
  logic                       fan_pwm_o;
  logic                       rtc_o;
  spih_out_t                  spih_i;
  logic                       sd_dat0_i;
  logic                       sd_cd_i;
  sd_pins_t                   sd_o;
  logic [3:0]                 spih_sd_o;
  i2c_out_t                   i2c_i;
  logic                       i2c_scl_pin_i;
  logic                       i2c_sda_pin_i;
  logic                       i2c_scl_oe_o;
  logic                       i2c_sda_oe_o;
  logic                       i2c_scl_drv_o;
  logic                       i2c_sda_drv_o;
  i2c_in_t                    i2c_sync_o;
  logic                       sd_card_present_o;

  int errors = 0;

  // Stimulus and expected values
  logic [FanSettingWidth-1:0] fan_set_tbl  [NumFanRows];
  int                         fan_high_tbl [NumFanRows];
  spih_out_t                  spih_tbl     [NumSdRows];
  logic                       dat0_tbl     [NumSdRows];
  sd_pins_t                   sd_exp_tbl   [NumSdRows];
  i2c_out_t                   i2c_tbl      [NumI2cRows];
  // Pin rows as {card detect, sda, scl}
  logic [2:0]                 pin_tbl      [NumPinRows];

  board_shell_top #(
    .RtcHalfPeriod ( RtcHalfPeriod ),
    .FanPrescale   ( FanPrescale   ),
    .SyncStages    ( SyncStages    )
  ) i_board_shell_top (
    .soc_clk           ( soc_clk           ),
    .rst_n             ( rst_n             ),
    .fan_sw_i          ( fan_sw_i          ),
    .fan_pwm_o         ( fan_pwm_o         ),
    .rtc_o             ( rtc_o             ),
    .spih_i            ( spih_i            ),
    .sd_dat0_i         ( sd_dat0_i         ),
    .sd_cd_i           ( sd_cd_i           ),
    .sd_o              ( sd_o              ),
    .spih_sd_o         ( spih_sd_o         ),
    .i2c_i             ( i2c_i             ),
    .i2c_scl_pin_i     ( i2c_scl_pin_i     ),
    .i2c_sda_pin_i     ( i2c_sda_pin_i     ),
    .i2c_scl_oe_o      ( i2c_scl_oe_o      ),
    .i2c_sda_oe_o      ( i2c_sda_oe_o      ),
    .i2c_scl_drv_o     ( i2c_scl_drv_o     ),
    .i2c_sda_drv_o     ( i2c_sda_drv_o     ),
    .i2c_sync_o        ( i2c_sync_o        ),
    .sd_card_present_o ( sd_card_present_o )
  );

  // 40 ns period
  always #20 soc_clk = ~soc_clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("** Error: %s expected %0h actual %0h", name, exp_val, act_val);
      errors++;
    end
  endtask

  // Counts cycles up to the next 0-to-1 step of rtc_o
  task automatic wait_rtc_rise(input string what, output int cycles);
    logic prev;
    bit   seen;
    prev   = rtc_o;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < RtcTimeout) begin
      @(posedge soc_clk);
      #2;
      cycles++;
      if (!prev && rtc_o) begin
        seen = 1'b1;
      end
      prev = rtc_o;
    end
    if (!seen) begin
      $display("Timeout: rtc_o did not rise within %0d cycles (%s)", RtcTimeout, what);
      errors++;
    end
  endtask

  task automatic count_fan_high(output int high_cnt);
    high_cnt = 0;
    for (int c = 0; c < FanPeriod; c++) begin
      @(posedge soc_clk);
      #2;
      if (fan_pwm_o) begin
        high_cnt++;
      end
    end
  endtask

  // Idle-high rule for the SD slot in SPI mode
  // A line whose enable is clear floats high
  function automatic sd_pins_t sd_expected(input spih_out_t s);
    sd_pins_t r;
    r.sclk  = s.sck | ~s.sck_en;
    r.dat3  = s.csb[0] | ~s.csb_en[0];
    r.cmd   = s.sd[0] | ~s.sd_en[0];
    r.dat12 = 2'b11;
    return r;
  endfunction

  // New pin levels must show up exactly SyncStages edges later
  task automatic check_sync_latency(input int row, input logic [2:0] old_pins,
                                    input logic [2:0] new_pins);
    {sd_cd_i, i2c_sda_pin_i, i2c_scl_pin_i} = new_pins;
    for (int s = 1; s <= SyncStages; s++) begin
      @(posedge soc_clk);
      #2;
      check_value($sformatf("pin sync row %0d edge %0d", row, s),
                  32'((s < SyncStages) ? old_pins : new_pins),
                  32'({sd_card_present_o, i2c_sync_o.sda, i2c_sync_o.scl}));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int cycles;
    int high_cnt;
    int n;
    soc_clk       = 1'b0;
    rst_n         = 1'b0;
    fan_sw_i      = '0;
    spih_i        = '0;
    sd_dat0_i     = 1'b0;
    sd_cd_i       = 1'b0;
    i2c_i         = '0;
    i2c_scl_pin_i = 1'b1;
    i2c_sda_pin_i = 1'b1;
    void'($urandom(43));

    // Fill the tables
    fan_set_tbl[0] = 4'd0;
    fan_set_tbl[1] = 4'd1;
    fan_set_tbl[2] = 4'd7;
    fan_set_tbl[3] = 4'd15;
    fan_set_tbl[4] = 4'($urandom);
    for (int i = 0; i < NumFanRows; i++) begin
      fan_high_tbl[i] = int'(fan_set_tbl[i]) * FanPrescale;
    end
    spih_tbl[0] = 14'h0000;
    dat0_tbl[0] = 1'b0;
    sd_exp_tbl[0] = 5'b11111;
    spih_tbl[1] = 14'b0_1_00_01_0000_0001;
    dat0_tbl[1] = 1'b1;
    sd_exp_tbl[1] = 5'b00011;
    // Only bit 0 of csb and sd reaches the slot
    spih_tbl[2] = 14'b1_1_00_10_0000_1110;
    dat0_tbl[2] = 1'b0;
    sd_exp_tbl[2] = 5'b11111;
    spih_tbl[3] = 14'b0_0_00_01_0001_0001;
    dat0_tbl[3] = 1'b1;
    sd_exp_tbl[3] = 5'b11011;
    for (int i = 4; i < NumSdRows; i++) begin
      spih_tbl[i]   = 14'($urandom);
      dat0_tbl[i]   = 1'($urandom);
      sd_exp_tbl[i] = sd_expected(spih_tbl[i]);
    end
    for (int i = 0; i < NumI2cRows; i++) begin
      i2c_tbl[i] = 4'($urandom);
    end
    pin_tbl[0] = 3'b100;
    pin_tbl[1] = 3'b111;
    pin_tbl[2] = 3'b001;
    pin_tbl[3] = 3'b110;
    pin_tbl[4] = 3'b011;

    // Reset values, during and after reset
    repeat (ResetCycles) @(posedge soc_clk);
    #2;
    check_value("reset fan_pwm_o", 32'(1'b0), 32'(fan_pwm_o));
    check_value("reset rtc_o", 32'(1'b0), 32'(rtc_o));
    check_value("reset i2c_sync_o", 32'(2'b11), 32'(i2c_sync_o));
    check_value("reset sd_card_present_o", 32'(1'b0), 32'(sd_card_present_o));
    rst_n = 1'b1;
    repeat (SyncStages + 1) @(posedge soc_clk);
    #2;
    check_value("post reset fan_pwm_o", 32'(1'b0), 32'(fan_pwm_o));
    check_value("post reset rtc_o", 32'(1'b0), 32'(rtc_o));
    check_value("post reset i2c_sync_o", 32'(2'b11), 32'(i2c_sync_o));
    check_value("post reset sd_card_present_o", 32'(1'b0), 32'(sd_card_present_o));

    // RTC period over three periods
    wait_rtc_rise("first edge", cycles);
    for (int p = 0; p < 3; p++) begin
      wait_rtc_rise("period", cycles);
      check_value($sformatf("rtc period %0d", p), 32'(2 * RtcHalfPeriod), 32'(cycles));
    end

    // Fan duty table
    for (int i = 0; i < NumFanRows; i++) begin
      fan_sw_i = fan_set_tbl[i];
      repeat (2 * FanPeriod) @(posedge soc_clk);
      #2;
      count_fan_high(high_cnt);
      check_value($sformatf("fan duty setting %0d", fan_set_tbl[i]),
                  32'(fan_high_tbl[i]), 32'(high_cnt));
    end

    // SD mapping table
    for (int i = 0; i < NumSdRows; i++) begin
      @(posedge soc_clk);
      #2;
      spih_i    = spih_tbl[i];
      sd_dat0_i = dat0_tbl[i];
      @(negedge soc_clk);
      check_value($sformatf("sd_o row %0d", i), 32'(sd_exp_tbl[i]), 32'(sd_o));
      check_value($sformatf("spih_sd_o row %0d", i),
                  32'(dat0_tbl[i] ? 4'b0010 : 4'b0000), 32'(spih_sd_o));
    end

    // I2C drive, same cycle
    for (int i = 0; i < NumI2cRows; i++) begin
      @(posedge soc_clk);
      #2;
      i2c_i = i2c_tbl[i];
      @(negedge soc_clk);
      check_value($sformatf("i2c drive row %0d", i),
                  32'({i2c_tbl[i].scl_en, i2c_tbl[i].sda_en, i2c_tbl[i].scl, i2c_tbl[i].sda}),
                  32'({i2c_scl_oe_o, i2c_sda_oe_o, i2c_scl_drv_o, i2c_sda_drv_o}));
    end

    // Pin synchronizers, starting from the idle levels
    @(posedge soc_clk);
    #2;
    for (int i = 0; i < NumPinRows; i++) begin
      check_sync_latency(i, (i == 0) ? 3'b011 : pin_tbl[i-1], pin_tbl[i]);
    end

    // Asynchronous reset while the fan runs flat out
    fan_sw_i = 4'd15;
    repeat (2 * FanPeriod) @(posedge soc_clk);
    #2;
    n = 0;
    while (!(fan_pwm_o && rtc_o) && n < 2 * FanPeriod) begin
      @(posedge soc_clk);
      #2;
      n++;
    end
    if (!(fan_pwm_o && rtc_o)) begin
      $display("Timeout: fan_pwm_o and rtc_o were never high together before the reset");
      errors++;
    end
    rst_n = 1'b0;
    #1;
    check_value("async reset fan_pwm_o", 32'(1'b0), 32'(fan_pwm_o));
    check_value("async reset rtc_o", 32'(1'b0), 32'(rtc_o));
    repeat (ResetCycles) @(posedge soc_clk);
    #2;
    rst_n = 1'b1;
    wait_rtc_rise("after mid-run reset", cycles);

    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== board_shell.f ====
verilog/board_pkg.sv
verilog/rst_sync.sv
verilog/rtc_clk_div.sv
verilog/fan_pwm_ctrl.sv
verilog/board_pad_ctrl.sv
verilog/board_shell_top.sv
verif/tb_board_shell.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the board shell testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary -f board_shell.f --top-module tb_board_shell -o tb_board_shell

./obj_dir/tb_board_shell > "$LOG" 2>&1
cat "$LOG"

# The log decides the result
if grep -qF '*** PASSED ***' "$LOG"; then
  echo "Simulation result: pass"
else
  echo "Simulation result: fail"
  exit 1
fi
